// ==== Makefile ====
TOP = rv_core_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== compile.f ====
+incdir+include
verilog/rv_core_pkg.sv
verilog/inst_decoder.sv
verilog/stage_reg.sv
verilog/int_alu.sv
verilog/int_regfile.sv
verilog/pipe_ctrl.sv
verilog/rv_core_top.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// ==== include/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// datapath and register file geometry
`define XLEN        64
`define REG_ADDR_W  5
`define NUM_REGS    32
`define SHAMT_W     6           // rv64 shift amount width

// first fetch address after reset
`define RESET_PC    64'h0000_0000_8000_0000

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011

`define EBREAK_INST 32'h0010_0073

`endif

// ==== verif/rv_core_props.sv ====
`include "rv_core_consts.svh"

module rv_core_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   wb_valid_i,
    input logic                   wb_wen_i,
    input logic [`REG_ADDR_W-1:0] wb_rd_i,
    input logic                   ebreak_i,
    input logic                   illegal_i,
    input logic                   halted_i
);
    timeunit 1ns;
    timeprecision 100ps;

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_valid_i))
        else $error("wb_valid_o is unknown");

    // an instruction is either an ebreak or illegal, never both
    a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ebreak_i && illegal_i))
        else $error("ebreak_o and illegal_o high together");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted_i |=> halted_i)
        else $error("halted_o dropped without reset");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_wen_i |-> wb_rd_i != '0)
        else $error("wb_wen_o high with wb_rd_o equal to x0");

endmodule

bind rv_core_top rv_core_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_valid_i (wb_valid_o),
    .wb_wen_i   (wb_wen_o),
    .wb_rd_i    (wb_rd_o),
    .ebreak_i   (ebreak_o),
    .illegal_i  (illegal_o),
    .halted_i   (halted_o)
);

// ==== verif/rv_core_tb.sv ====
`include "rv_core_consts.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic                   valid;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic                   ebreak;
        logic                   illegal;
    } exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   inst_valid_i;
    logic [31:0]            inst_i;
    logic [`XLEN-1:0]       pc_i;
    logic                   wb_valid_o;
    logic                   wb_wen_o;
    logic [`REG_ADDR_W-1:0] wb_rd_o;
    logic [`XLEN-1:0]       wb_data_o;
    logic                   ebreak_o;
    logic                   illegal_o;
    logic                   halted_o;

    exp_t                   exp_q[$];               // one entry per driven cycle
    logic [`XLEN-1:0]       model_regs [`NUM_REGS];
    logic [`XLEN-1:0]       pc;
    logic                   halt_pend;
    logic                   exp_halted;
    int                     errors;
    int                     checks;

    rv_core_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .wb_valid_o   (wb_valid_o),
        .wb_wen_o     (wb_wen_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .ebreak_o     (ebreak_o),
        .illegal_o    (illegal_o),
        .halted_o     (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // mostly x0..x7 so producers and consumers collide
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $urandom;
        if (r[7:6] == 2'b00) begin
            return r[4:0];
        end
        return {2'b00, r[2:0]};
    endfunction

    // op index: add sub and or xor sll srl sra slt sltu, then lui pass
    function automatic logic [63:0] ref_alu(input logic [3:0] op, input logic [63:0] a,
                                            input logic [63:0] b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[5:0];
            4'd6:    return a >> b[5:0];
            4'd7:    return $signed(a) >>> b[5:0];
            4'd8:    return {63'b0, $signed(a) < $signed(b)};
            4'd9:    return {63'b0, a < b};
            default: return b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input logic [3:0] op);
        case (op)
            4'd2:       return 3'b111;
            4'd3:       return 3'b110;
            4'd4:       return 3'b100;
            4'd5:       return 3'b001;
            4'd6, 4'd7: return 3'b101;
            4'd8:       return 3'b010;
            4'd9:       return 3'b011;
            default:    return 3'b000;      // add and sub
        endcase
    endfunction

    // builds one random instruction and its retirement, model updated at issue
    task automatic gen_inst(output logic [31:0] word, output exp_t e);
        logic [31:0]      r1;
        logic [31:0]      r2;
        logic [31:0]      sel;
        logic [3:0]       kind;
        logic [3:0]       op;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [11:0]      imm12;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        r1      = $urandom;
        r2      = $urandom;
        kind    = r1[31:28];
        rd      = pick_reg();
        rs1     = pick_reg();
        rs2     = pick_reg();
        a       = model_regs[rs1];
        e       = '0;
        e.valid = 1'b1;
        e.rd    = rd;
        if (kind == 4'd14) begin
            word      = {r2[24:0], 7'b0001011};     // custom-0 opcode
            e.rd      = word[11:7];
            e.illegal = 1'b1;
        end else if (kind == 4'd12 || kind == 4'd13) begin
            b      = {{32{r2[31]}}, r2[31:12], 12'b0};
            word   = {r2[31:12], rd, (kind == 4'd12) ? 7'b0110111 : 7'b0010111};
            e.data = (kind == 4'd12) ? b : pc + b;
        end else if (kind >= 4'd6) begin
            sel   = r2 % 32'd9;
            op    = (sel == 32'd0) ? 4'd0 : sel[3:0] + 4'd1;    // no subi
            imm12 = r1[11:0];
            if (op == 4'd5 || op == 4'd6 || op == 4'd7) begin
                imm12 = {1'b0, op == 4'd7, 4'b0000, r1[5:0]};
            end
            b      = {{52{imm12[11]}}, imm12};
            word   = {imm12, rs1, funct3_of(op), rd, 7'b0010011};
            e.data = ref_alu(op, a, b);
        end else begin
            sel    = r2 % 32'd10;
            op     = sel[3:0];
            b      = model_regs[rs2];
            word   = {1'b0, op == 4'd1 || op == 4'd7, 5'b00000, rs2, rs1, funct3_of(op),
                      rd, 7'b0110011};
            e.data = ref_alu(op, a, b);
        end
        e.wen = !e.illegal && rd != 5'd0;
        if (e.wen) begin
            model_regs[rd] = e.data;
        end
    endtask

    task automatic drive_cycle(input logic valid, input logic [31:0] word, input exp_t e);
        @(posedge clk);
        exp_halted = halt_pend;             // ebreak from an earlier edge
        inst_valid_i <= valid;
        inst_i       <= word;
        pc_i         <= pc;
        exp_q.push_back(e);
        if (valid) begin
            pc = pc + 64'd4;
        end
    endtask

    // outputs of the instruction driven two edges back
    always @(negedge clk) begin
        exp_t e;
        if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            check_val("wb_valid_o", {63'b0, wb_valid_o}, {63'b0, e.valid});
            check_val("wb_wen_o", {63'b0, wb_wen_o}, {63'b0, e.wen});
            check_val("ebreak_o", {63'b0, ebreak_o}, {63'b0, e.ebreak});
            check_val("illegal_o", {63'b0, illegal_o}, {63'b0, e.illegal});
            check_val("halted_o", {63'b0, halted_o}, {63'b0, exp_halted});
            if (e.valid) begin
                check_val("wb_rd_o", {59'b0, wb_rd_o}, {59'b0, e.rd});
            end
            if (e.wen) begin
                check_val("wb_data_o", wb_data_o, e.data);
            end
        end
    end

    initial begin
        exp_t        e;
        logic [31:0] word;
        logic [31:0] r;
        int          waited;
        r            = $urandom(32'h980a_76c4);
        errors       = 0;
        checks       = 0;
        pc           = `RESET_PC;
        halt_pend    = 1'b0;
        exp_halted   = 1'b0;
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        e = '0;
        exp_q.push_back(e);                 // pipeline is empty out of reset
        exp_q.push_back(e);
        for (int i = 0; i < 400; i++) begin
            r = $urandom;
            if (r[2:0] == 3'b000) begin
                e = '0;
                drive_cycle(1'b0, r, e);    // idle gap
            end else begin
                gen_inst(word, e);
                drive_cycle(1'b1, word, e);
            end
        end
        e        = '0;
        e.valid  = 1'b1;
        e.ebreak = 1'b1;
        drive_cycle(1'b1, `EBREAK_INST, e);
        halt_pend = 1'b1;
        e         = '0;
        waited    = 0;
        do begin
            r = $urandom;
            drive_cycle(1'b1, r, e);        // must be dropped
            @(negedge clk);
            waited++;
        end while (!halted_o && waited < 10);
        if (!halted_o) begin
            $display("timeout: halted_o did not rise within %0d cycles of EBREAK", waited);
            $display("test failed");
            $finish;
        end else begin
            for (int i = 0; i < 8; i++) begin
                r = $urandom;
                drive_cycle(1'b1, r, e);
            end
            @(negedge clk);
            @(posedge clk);
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

// ==== verilog/inst_decoder.sv ====
`include "rv_core_consts.svh"

module inst_decoder import rv_core_pkg::*; (
    input  logic [31:0]             inst_i,
    input  logic [`XLEN-1:0]        pc_i,
    output alu_op_e                 alu_op_o,
    output logic [`REG_ADDR_W-1:0]  rs1_o,
    output logic [`REG_ADDR_W-1:0]  rs2_o,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic                    uses_rs1_o,
    output logic                    uses_rs2_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic                    src1_pc_o,
    output logic                    src2_imm_o,
    output logic                    reg_wen_o,
    output logic                    ebreak_o,
    output logic                    illegal_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i_type;
    logic [`XLEN-1:0] imm_u_type;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    assign imm_i_type = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    assign imm_o = (opcode == `OPC_LUI || opcode == `OPC_AUIPC) ? imm_u_type : imm_i_type;

    always_comb begin
        alu_op_o   = ALU_ADD;
        uses_rs1_o = 1'b0;
        uses_rs2_o = 1'b0;
        src1_pc_o  = 1'b0;
        src2_imm_o = 1'b0;
        reg_wen_o  = 1'b0;
        ebreak_o   = 1'b0;
        illegal_o  = 1'b0;
        case (opcode)
            `OPC_OP: begin
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
                reg_wen_o  = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
                    {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
                    {7'b0000000, 3'b010}: alu_op_o = ALU_SLT;
                    {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
                    {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
                    {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
                    {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
                    {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
                    {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
                    default:              illegal_o = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                uses_rs1_o = 1'b1;
                src2_imm_o = 1'b1;
                reg_wen_o  = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: begin           // slli, 6-bit shamt
                        alu_op_o  = ALU_SLL;
                        illegal_o = (inst_i[31:26] != 6'b000000);
                    end
                    default: begin          // srli / srai
                        alu_op_o  = inst_i[30] ? ALU_SRA : ALU_SRL;
                        illegal_o = ({inst_i[31], inst_i[29:26]} != 5'b00000);
                    end
                endcase
            end
            `OPC_LUI: begin
                alu_op_o   = ALU_PASS_B;
                src2_imm_o = 1'b1;
                reg_wen_o  = 1'b1;
            end
            `OPC_AUIPC: begin
                src1_pc_o  = 1'b1;
                src2_imm_o = 1'b1;
                reg_wen_o  = 1'b1;
            end
            `OPC_SYSTEM: begin
                ebreak_o  = (inst_i == `EBREAK_INST);
                illegal_o = (inst_i != `EBREAK_INST);
            end
            default: illegal_o = 1'b1;
        endcase
        // a fetch address off a word boundary cannot hold a valid instruction
        if (pc_i[1:0] != 2'b00) begin
            illegal_o = 1'b1;
            ebreak_o  = 1'b0;
        end
        if (illegal_o) begin
            reg_wen_o = 1'b0;
        end
    end

endmodule

// ==== verilog/int_alu.sv ====
`include "rv_core_consts.svh"

module int_alu import rv_core_pkg::*; (
    input  alu_op_e          op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic [`XLEN-1:0] result_o
);

    logic [`SHAMT_W-1:0] shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    assign shamt       = b_i[`SHAMT_W-1:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $signed(a_i) >>> shamt;  // keeps the sign bit
            ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== verilog/int_regfile.sv ====
`include "rv_core_consts.svh"

module int_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    input  logic                   wen_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin     // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read, x0 forced to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== verilog/pipe_ctrl.sv ====
`include "rv_core_consts.svh"

module pipe_ctrl import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid_i,
    input  logic                   ebreak_i,
    input  logic [`REG_ADDR_W-1:0] rs1_i,
    input  logic [`REG_ADDR_W-1:0] rs2_i,
    input  logic                   uses_rs1_i,
    input  logic                   uses_rs2_i,
    input  id_ex_t                 id_ex_i,
    input  ex_wb_t                 ex_wb_i,
    output logic                   issue_o,
    output fwd_sel_e               fwd_sel1_o,
    output fwd_sel_e               fwd_sel2_o,
    output logic                   halted_o
);

    logic halted_q;

    // once halted, strobes are dropped until reset
    assign issue_o  = inst_valid_i && !halted_q;
    assign halted_o = halted_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q <= 1'b0;
        end else if (issue_o && ebreak_i) begin
            halted_q <= 1'b1;
        end
    end

    // youngest producer wins, so ex is checked before wb
    function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs,
                                          input logic                   uses);
        fwd_sel_e sel;
        sel = FWD_REGFILE;
        if (uses && rs != '0) begin
            if (id_ex_i.valid && id_ex_i.reg_wen && id_ex_i.rd == rs) begin
                sel = FWD_FROM_EX;
            end else if (ex_wb_i.valid && ex_wb_i.reg_wen && ex_wb_i.rd == rs) begin
                sel = FWD_FROM_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_sel1_o = pick_src(rs1_i, uses_rs1_i);
        fwd_sel2_o = pick_src(rs2_i, uses_rs2_i);
    end

endmodule

// ==== verilog/rv_core_pkg.sv ====
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B              // lui just passes the immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_EX,            // alu result of the instruction in ex
        FWD_FROM_WB             // registered result in writeback
    } fwd_sel_e;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        alu_op_e                alu_op;
        logic [`XLEN-1:0]       src1;   // operands after forwarding
        logic [`XLEN-1:0]       src2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_wen;
        logic                   ebreak;
        logic                   illegal;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_wen;
        logic [`XLEN-1:0]       data;
        logic                   ebreak;
        logic                   illegal;
    } ex_wb_t;

endpackage

// ==== verilog/rv_core_top.sv ====
`include "rv_core_consts.svh"

module rv_core_top import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid_i,
    input  logic [31:0]            inst_i,
    input  logic [`XLEN-1:0]       pc_i,
    output logic                   wb_valid_o,
    output logic                   wb_wen_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o,
    output logic                   ebreak_o,
    output logic                   illegal_o,
    output logic                   halted_o
);

    alu_op_e                dec_alu_op;
    logic [`REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
    logic                   dec_uses_rs1, dec_uses_rs2;
    logic [`XLEN-1:0]       dec_imm;
    logic                   dec_src1_pc, dec_src2_imm;
    logic                   dec_reg_wen, dec_ebreak, dec_illegal;

    logic                   issue;
    fwd_sel_e               fwd_sel1, fwd_sel2;
    logic [`XLEN-1:0]       rf_rdata1, rf_rdata2;
    logic [`XLEN-1:0]       rs1_val, rs2_val;
    logic [`XLEN-1:0]       alu_result;
    logic                   wb_wen;

    id_ex_t                 id_ex_d, id_ex_q;
    ex_wb_t                 ex_wb_d, ex_wb_q;

    inst_decoder u_decoder (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .alu_op_o   (dec_alu_op),
        .rs1_o      (dec_rs1),
        .rs2_o      (dec_rs2),
        .rd_o       (dec_rd),
        .uses_rs1_o (dec_uses_rs1),
        .uses_rs2_o (dec_uses_rs2),
        .imm_o      (dec_imm),
        .src1_pc_o  (dec_src1_pc),
        .src2_imm_o (dec_src2_imm),
        .reg_wen_o  (dec_reg_wen),
        .ebreak_o   (dec_ebreak),
        .illegal_o  (dec_illegal)
    );

    int_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (dec_rs1),
        .raddr2_i (dec_rs2),
        .wen_i    (wb_wen),
        .waddr_i  (ex_wb_q.rd),
        .wdata_i  (ex_wb_q.data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    pipe_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .ebreak_i     (dec_ebreak),
        .rs1_i        (dec_rs1),
        .rs2_i        (dec_rs2),
        .uses_rs1_i   (dec_uses_rs1),
        .uses_rs2_i   (dec_uses_rs2),
        .id_ex_i      (id_ex_q),
        .ex_wb_i      (ex_wb_q),
        .issue_o      (issue),
        .fwd_sel1_o   (fwd_sel1),
        .fwd_sel2_o   (fwd_sel2),
        .halted_o     (halted_o)
    );

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e         sel,
                                                 input logic [`XLEN-1:0] rf_val);
        case (sel)
            FWD_FROM_EX: return alu_result;
            FWD_FROM_WB: return ex_wb_q.data;
            default:     return rf_val;
        endcase
    endfunction

    always_comb begin
        rs1_val = fwd_mux(fwd_sel1, rf_rdata1);
        rs2_val = fwd_mux(fwd_sel2, rf_rdata2);
    end

    // flags gated by issue so dropped strobes leave a bubble
    always_comb begin
        id_ex_d.valid   = issue;
        id_ex_d.pc      = pc_i;
        id_ex_d.alu_op  = dec_alu_op;
        id_ex_d.src1    = dec_src1_pc ? pc_i : rs1_val;     // auipc
        id_ex_d.src2    = dec_src2_imm ? dec_imm : rs2_val;
        id_ex_d.rd      = dec_rd;
        id_ex_d.reg_wen = issue && dec_reg_wen;
        id_ex_d.ebreak  = issue && dec_ebreak;
        id_ex_d.illegal = issue && dec_illegal;
    end

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (id_ex_d),
        .q_o   (id_ex_q)
    );

    int_alu u_alu (
        .op_i     (id_ex_q.alu_op),
        .a_i      (id_ex_q.src1),
        .b_i      (id_ex_q.src2),
        .result_o (alu_result)
    );

    always_comb begin
        ex_wb_d.valid   = id_ex_q.valid;
        ex_wb_d.rd      = id_ex_q.rd;
        ex_wb_d.reg_wen = id_ex_q.reg_wen;
        ex_wb_d.data    = alu_result;
        ex_wb_d.ebreak  = id_ex_q.ebreak;
        ex_wb_d.illegal = id_ex_q.illegal;
    end

    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (ex_wb_d),
        .q_o   (ex_wb_q)
    );

    assign wb_wen = ex_wb_q.valid && ex_wb_q.reg_wen && ex_wb_q.rd != '0;   // no x0 write

    assign wb_valid_o = ex_wb_q.valid;
    assign wb_wen_o   = wb_wen;
    assign wb_rd_o    = ex_wb_q.rd;
    assign wb_data_o  = ex_wb_q.data;
    assign ebreak_o   = ex_wb_q.ebreak;
    assign illegal_o  = ex_wb_q.illegal;

endmodule

// ==== verilog/stage_reg.sv ====
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d_i,
    output payload_t q_o
);

    // loads every cycle, no stall or flush in this pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;          // clears valid and all flags
        end else begin
            q_o <= d_i;
        end
    end

endmodule
